// ==== files.f ====
design/mazePkg.sv
design/trackSampler.sv
design/phaseTimer.sv
design/routeFsm.sv
design/decisionStack.sv
design/driveCommand.sv
design/mazeCarTop.sv
bench/mazeCarTb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the maze car testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
    -f files.f --top-module mazeCarTb -o mazeCarSim

./obj_dir/mazeCarSim

// ==== bench/mazeCarTb.sv ====
`timescale 1ns/1ps

module mazeCarTb
    import mazePkg::*;
();

    localparam int StableCycles  = 3;
    localparam int CountCycles   = 20;
    localparam int PauseCycles   = 12;
    localparam int StackDepth    = 16;
    localparam int BlinkCycles   = 4;
    localparam int DepthW        = $clog2(StackDepth + 1);
    localparam int TimeoutCycles = 4000;

    logic              clk;
    logic              rst;
    logic              enable;
    logic              trackLeft;
    logic              trackMid;
    logic              trackRight;
    driveT             motorLeft;
    driveT             motorRight;
    logic [15:0]       statusLed;
    logic [DepthW-1:0] stackDepth;
    decisionT          stackTop;

    int                cycleCount = 0;
    int                activeCycles = 0;
    logic [3:0]        wheels;
    int unsigned       seedValue;
    int                glitchIndex;
    int                glitchLen;
    logic [2:0]        glitchPattern;
    int                stateCycles;

    mazeCarTop #(
        .StableCycles(StableCycles),
        .CountCycles (CountCycles),
        .PauseCycles (PauseCycles),
        .StackDepth  (StackDepth),
        .BlinkCycles (BlinkCycles)
    ) i_dut (
        .clk       (clk),
        .rst       (rst),
        .enable    (enable),
        .trackLeft (trackLeft),
        .trackMid  (trackMid),
        .trackRight(trackRight),
        .motorLeft (motorLeft),
        .motorRight(motorRight),
        .statusLed (statusLed),
        .stackDepth(stackDepth),
        .stackTop  (stackTop)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Wheel pair {left, right} expected for a state
    function automatic logic [3:0] expectedWheels(input navStateT s);
        driveT leftWheel;
        driveT rightWheel;
        leftWheel  = driveStop;
        rightWheel = driveStop;
        if (s == navStraight || s == navNudgeRight || s == navRight || s == navBack) begin
            leftWheel = driveForward;
        end else if (s == navLeft) begin
            leftWheel = driveReverse;
        end
        if (s == navStraight || s == navNudgeLeft || s == navLeft) begin
            rightWheel = driveForward;
        end else if (s == navRight || s == navBack) begin
            rightWheel = driveReverse;
        end
        return {leftWheel, rightWheel};
    endfunction

    task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
                              input string what);
        if (actual !== expected) begin
            $display("ERROR at %0t: %s is %0h, expected %0h", $time, what, actual, expected);
            $display("STATUS: FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    // New sensor pattern {left, mid, right} from the next rising edge
    task automatic driveTrack(input logic [2:0] pattern);
        @(posedge clk);
        trackLeft  <= pattern[2];
        trackMid   <= pattern[1];
        trackRight <= pattern[0];
    endtask

    task automatic waitState(input navStateT target);
        @(negedge clk);
        while (statusLed[15:12] != target) begin
            @(negedge clk);
        end
    endtask

    task automatic waitRoad(input roadT target);
        @(negedge clk);
        while (statusLed[2:0] != target) begin
            @(negedge clk);
        end
    endtask

    task automatic waitTop(input decisionT target);
        @(negedge clk);
        while (stackTop != target) begin
            @(negedge clk);
        end
    endtask

    // Number of cycles the LED state field shows target
    task automatic measureState(input navStateT target, output int cycles);
        waitState(target);
        cycles = 0;
        while (statusLed[15:12] == target) begin
            cycles = cycles + 1;
            @(negedge clk);
        end
    endtask

    // Wheels and LED word against the state shown in the same cycle
    always @(negedge clk) begin
        if (!rst) begin
            wheels = expectedWheels(navStateT'(statusLed[15:12]));
            checkValue(32'(motorLeft), 32'(wheels[3:2]), "left wheel");
            checkValue(32'(motorRight), 32'(wheels[1:0]), "right wheel");
            checkValue(32'({statusLed[11:9], statusLed[7:3]}), 0, "unused LED bits");
            // Blink starts low and toggles every BlinkCycles while stopped or backing
            if (statusLed[15:12] == navStop || statusLed[15:12] == navBack) begin
                checkValue(32'(statusLed[8]), 32'((activeCycles / BlinkCycles) % 2),
                           "blink bit");
                activeCycles = activeCycles + 1;
            end else begin
                checkValue(32'(statusLed[8]), 0, "blink bit");
                activeCycles = 0;
            end
        end
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= TimeoutCycles) begin
            $display("Timeout: the maze sequence did not finish within %0d cycles",
                     TimeoutCycles);
            $display("STATUS: FAIL");
            $fatal(1, "timeout");
        end
    end

    initial begin
        seedValue  = $urandom(32'h3a514935);
        rst        = 1'b1;
        enable     = 1'b0;
        trackLeft  = 1'b0;
        trackMid   = 1'b0;
        trackRight = 1'b0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;

        // Reset state
        @(negedge clk);
        checkValue(32'(statusLed[15:12]), 32'(navIdle), "state after reset");
        checkValue(32'(motorLeft), 32'(driveStop), "left wheel after reset");
        checkValue(32'(motorRight), 32'(driveStop), "right wheel after reset");
        checkValue(32'(stackDepth), 0, "depth after reset");
        checkValue(32'(stackTop), 32'(decNone), "top after reset");

        // Start countdown and then line following
        @(posedge clk);
        enable <= 1'b1;
        waitState(navStart);
        driveTrack(3'b010);
        measureState(navCount, stateCycles);
        checkValue(32'(stateCycles), 32'(CountCycles + 1), "count phase length");
        checkValue(32'(statusLed[15:12]), 32'(navStraight), "state after count");
        checkValue(32'(motorLeft), 32'(driveForward), "left wheel straight");
        checkValue(32'(motorRight), 32'(driveForward), "right wheel straight");
        driveTrack(3'b100);
        waitState(navNudgeLeft);
        checkValue(32'(motorLeft), 32'(driveStop), "left wheel nudge");
        checkValue(32'(motorRight), 32'(driveForward), "right wheel nudge");

        // Short glitches must not reach the road field
        for (glitchIndex = 0; glitchIndex < 4; glitchIndex++) begin
            glitchPattern = 3'($urandom);
            if (glitchPattern == 3'b100) begin
                glitchPattern = 3'b001;
            end
            glitchLen = 1 + ($urandom % (StableCycles - 1));
            driveTrack(glitchPattern);
            repeat (glitchLen - 1) @(posedge clk);
            driveTrack(3'b100);
            repeat (StableCycles + 4) begin
                @(negedge clk);
                checkValue(32'(statusLed[2:0]), 32'(roadLeftSlight), "road under glitch");
            end
        end
        driveTrack(3'b010);
        waitRoad(roadStraight);
        waitState(navStraight);

        // Crossing pushes a straight choice and the fork turns it into left
        driveTrack(3'b111);
        waitState(navChoose);
        waitTop(decStraight);
        checkValue(32'(stackDepth), 1, "depth after push");
        driveTrack(3'b101);
        waitState(navStop);
        driveTrack(3'b010);
        waitTop(decLeft);
        checkValue(32'(stackDepth), 1, "depth after replace");
        waitState(navLeft);

        // Leave the junction and hit a dead end
        driveTrack(3'b111);
        waitState(navStop);
        driveTrack(3'b010);
        waitState(navStraight);
        driveTrack(3'b000);
        waitState(navStop);
        waitState(navBack);
        driveTrack(3'b111);
        waitState(navStop);
        driveTrack(3'b010);
        waitTop(decRight);
        waitState(navRight);
        checkValue(32'(stackDepth), 1, "depth after backtrack");
        checkValue(32'(motorLeft), 32'(driveForward), "left wheel right turn");
        checkValue(32'(motorRight), 32'(driveReverse), "right wheel right turn");

        // Second dead end pops the last entry and the empty stack ends in error
        driveTrack(3'b111);
        waitState(navStop);
        driveTrack(3'b010);
        waitState(navStraight);
        driveTrack(3'b000);
        waitState(navBack);
        driveTrack(3'b111);
        measureState(navStop, stateCycles);
        checkValue(32'(stateCycles), 32'(PauseCycles + 1), "pause length");
        waitState(navError);
        checkValue(32'(stackDepth), 0, "depth after pop");
        checkValue(32'(stackTop), 32'(decNone), "top of empty stack");
        @(posedge clk);
        enable <= 1'b0;
        waitState(navIdle);
        checkValue(32'(motorLeft), 32'(driveStop), "left wheel disabled");
        checkValue(32'(motorRight), 32'(driveStop), "right wheel disabled");

        $display("STATUS: PASS");
        $finish;
    end

endmodule

// ==== design/mazeCarTop.sv ====
`timescale 1ns/1ps

module mazeCarTop
    import mazePkg::*;
#(
    parameter int StableCycles = 1000,
    parameter int CountCycles  = 300_000_000,
    parameter int PauseCycles  = 50_000_000,
    parameter int StackDepth   = 16,
    parameter int BlinkCycles  = 25_000_000
) (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              enable,
    input  logic                              trackLeft,
    input  logic                              trackMid,
    input  logic                              trackRight,
    output driveT                             motorLeft,
    output driveT                             motorRight,
    output logic [15:0]                       statusLed,
    output logic [$clog2(StackDepth + 1)-1:0] stackDepth,
    output decisionT                          stackTop
);

    roadT     road;
    navStateT state;
    logic     stackReq;
    stackOpT  stackOp;
    decisionT stackData;
    logic     stackAck;
    logic     stackEmpty;

    trackSampler #(.StableCycles(StableCycles)) sampler (
        .clk(clk), .rst(rst), .trackLeft(trackLeft), .trackMid(trackMid),
        .trackRight(trackRight), .road(road)
    );

    routeFsm #(.CountCycles(CountCycles), .PauseCycles(PauseCycles)) fsm (
        .clk(clk), .rst(rst), .enable(enable), .road(road), .state(state),
        .stackReq(stackReq), .stackOp(stackOp), .stackData(stackData),
        .stackAck(stackAck), .stackTop(stackTop), .stackEmpty(stackEmpty)
    );

    // Junction memory for backtracking
    decisionStack #(.StackDepth(StackDepth)) stack (
        .clk(clk), .rst(rst), .stackReq(stackReq), .stackOp(stackOp),
        .stackData(stackData), .stackAck(stackAck), .stackTop(stackTop),
        .stackDepth(stackDepth), .stackEmpty(stackEmpty)
    );

    driveCommand #(.BlinkCycles(BlinkCycles)) drive (
        .clk(clk), .rst(rst), .state(state), .road(road),
        .motorLeft(motorLeft), .motorRight(motorRight), .statusLed(statusLed)
    );

endmodule

// ==== design/driveCommand.sv ====
`timescale 1ns/1ps

module driveCommand
    import mazePkg::*;
#(
    parameter int BlinkCycles = 4
) (
    input  logic        clk,
    input  logic        rst,
    input  navStateT    state,
    input  roadT        road,
    output driveT       motorLeft,
    output driveT       motorRight,
    output logic [15:0] statusLed
);

    localparam int BlinkW = $clog2(BlinkCycles + 1);

    driveT             leftNext;
    driveT             rightNext;
    logic              blinkActive;
    logic              blink;
    logic [BlinkW-1:0] blinkCount;

    assign blinkActive = (state == navStop) || (state == navBack);

    // Wheel pair per state
    always_comb begin
        leftNext  = driveStop;
        rightNext = driveStop;
        case (state)
            navStraight: begin
                leftNext  = driveForward;
                rightNext = driveForward;
            end
            navNudgeLeft: rightNext = driveForward;
            navNudgeRight: leftNext = driveForward;
            navLeft: begin
                leftNext  = driveReverse;
                rightNext = driveForward;
            end
            navRight, navBack: begin
                leftNext  = driveForward;
                rightNext = driveReverse;
            end
            default: leftNext = driveStop;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            motorLeft  <= driveStop;
            motorRight <= driveStop;
            statusLed  <= 16'h0000;
            blink      <= 1'b0;
            blinkCount <= '0;
        end else begin
            motorLeft  <= leftNext;
            motorRight <= rightNext;
            statusLed  <= {state, 3'b000, blink && blinkActive, 5'b00000, road};
            if (!blinkActive) begin
                blink      <= 1'b0;
                blinkCount <= '0;
            end else if (blinkCount == BlinkW'(BlinkCycles - 1)) begin
                blink      <= !blink;
                blinkCount <= '0;
            end else begin
                blinkCount <= blinkCount + 1'b1;
            end
        end
    end

endmodule

// ==== design/decisionStack.sv ====
`timescale 1ns/1ps

module decisionStack
    import mazePkg::*;
#(
    parameter int StackDepth = 16
) (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              stackReq,
    input  stackOpT                           stackOp,
    input  decisionT                          stackData,
    output logic                              stackAck,
    output decisionT                          stackTop,
    output logic [$clog2(StackDepth + 1)-1:0] stackDepth,
    output logic                              stackEmpty
);

    localparam int DepthW = $clog2(StackDepth + 1);
    localparam int AddrW  = (StackDepth > 1) ? $clog2(StackDepth) : 1;

    decisionT          entries [StackDepth];
    logic              doOp;
    logic              stackFull;
    logic [AddrW-1:0]  pushAddr;
    logic [AddrW-1:0]  topAddr;

    assign stackEmpty = (stackDepth == '0);
    assign stackFull  = (stackDepth == DepthW'(StackDepth));
    assign pushAddr   = AddrW'(stackDepth);
    assign topAddr    = AddrW'(stackDepth - 1'b1);

    // One operation per request as the ack goes up
    assign doOp = stackReq && !stackAck;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            stackAck   <= 1'b0;
            stackDepth <= '0;
        end else begin
            if (doOp) begin
                stackAck <= 1'b1;
                if (stackOp == opPush && !stackFull) begin
                    stackDepth <= stackDepth + 1'b1;
                end else if (stackOp == opPop && !stackEmpty) begin
                    stackDepth <= stackDepth - 1'b1;
                end
            end else if (!stackReq && stackAck) begin
                stackAck <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (doOp && stackOp == opPush && !stackFull) begin
            entries[pushAddr] <= stackData;
        end else if (doOp && stackOp == opReplace && !stackEmpty) begin
            entries[topAddr] <= stackData;
        end
    end

    assign stackTop = stackEmpty ? decNone : entries[topAddr];

endmodule

// ==== design/routeFsm.sv ====
`timescale 1ns/1ps

module routeFsm
    import mazePkg::*;
#(
    parameter int CountCycles = 20,
    parameter int PauseCycles = 12
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     enable,
    input  roadT     road,
    output navStateT state,
    output logic     stackReq,
    output stackOpT  stackOp,
    output decisionT stackData,
    input  logic     stackAck,
    input  decisionT stackTop,
    input  logic     stackEmpty
);

    navStateT nextState;
    navStateT resumeState;
    navStateT nextResume;
    logic     checkpoint;
    logic     stackIdle;
    logic     opNeeded;
    stackOpT  nextOp;
    decisionT nextData;
    logic     stackGo;
    logic     timerStart;
    logic     timerPause;
    logic     timerDone;

    // No request in flight and the previous one fully closed
    assign stackIdle = !stackReq && !stackAck;

    always_comb begin
        nextState  = state;
        nextResume = resumeState;
        opNeeded   = 1'b0;
        nextOp     = opPush;
        nextData   = decNone;
        case (state)
            navIdle: if (enable) nextState = navStart;
            navStart: if (road == roadStraight) nextState = navCount;
            navCount: if (timerDone) nextState = navStraight;
            navStraight, navNudgeLeft, navNudgeRight: begin
                case (road)
                    roadLeftSlight, roadLeft: nextState = navNudgeLeft;
                    roadRightSlight, roadRight: nextState = navNudgeRight;
                    roadStraight, roadFork: nextState = navStraight;
                    roadLost: begin
                        nextState  = navStop;
                        nextResume = navBack;
                    end
                    default: begin
                        // A crossing remembers that we went straight first
                        if (checkpoint && stackIdle) begin
                            nextState = navChoose;
                            opNeeded  = 1'b1;
                            nextOp    = opPush;
                            nextData  = decStraight;
                        end
                    end
                endcase
            end
            navChoose: begin
                if (road == roadFork && stackIdle) begin
                    nextState  = navStop;
                    nextResume = navLeft;
                    opNeeded   = 1'b1;
                    nextOp     = opReplace;
                    nextData   = decLeft;
                end else if (road == roadCross && checkpoint) begin
                    nextState = navStraight;
                end
            end
            navLeft: begin
                if (road == roadFork && checkpoint && stackIdle) begin
                    nextState  = navStop;
                    nextResume = navRight;
                    opNeeded   = 1'b1;
                    nextOp     = opReplace;
                    nextData   = decRight;
                end else if (road == roadCross && checkpoint) begin
                    nextState  = navStop;
                    nextResume = navStraight;
                end
            end
            navRight: begin
                if (road == roadCross && checkpoint) begin
                    nextState  = navStop;
                    nextResume = navStraight;
                end
            end
            navBack: begin
                // Top and empty flag are only valid once the last op closed
                if (road == roadCross && stackIdle) begin
                    if (stackEmpty) begin
                        nextState = navError;
                    end else begin
                        nextState = navStop;
                        opNeeded  = 1'b1;
                        case (stackTop)
                            decStraight: begin
                                nextOp     = opReplace;
                                nextData   = decLeft;
                                nextResume = navLeft;
                            end
                            decLeft: begin
                                nextOp     = opReplace;
                                nextData   = decRight;
                                nextResume = navRight;
                            end
                            default: begin
                                // Drop this junction once all branches are tried
                                nextOp     = opPop;
                                nextResume = navBack;
                            end
                        endcase
                    end
                end
            end
            navStop: if (timerDone) nextState = resumeState;
            default: nextState = state;
        endcase
        if (!enable) begin
            nextState = navIdle;
        end
    end

    assign stackGo    = opNeeded && enable;
    assign timerPause = (nextState == navStop);
    assign timerStart = (nextState != state) && (nextState == navCount || timerPause);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state       <= navIdle;
            resumeState <= navIdle;
            checkpoint  <= 1'b0;
            stackReq    <= 1'b0;
        end else begin
            state       <= nextState;
            resumeState <= nextResume;
            // Armed once the crossing pattern has been left in this state
            if (nextState != state) begin
                checkpoint <= 1'b0;
            end else if (road != roadCross) begin
                checkpoint <= 1'b1;
            end
            if (stackReq && stackAck) begin
                stackReq <= 1'b0;
            end else if (stackGo) begin
                stackReq <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (stackGo) begin
            stackOp   <= nextOp;
            stackData <= nextData;
        end
    end

    phaseTimer #(
        .CountCycles(CountCycles),
        .PauseCycles(PauseCycles)
    ) timer (
        .clk     (clk),
        .rst     (rst),
        .start   (timerStart),
        .usePause(timerPause),
        .done    (timerDone)
    );

endmodule

// ==== design/phaseTimer.sv ====
`timescale 1ns/1ps

module phaseTimer
    import mazePkg::*;
#(
    parameter int CountCycles = 20,
    parameter int PauseCycles = 12
) (
    input  logic clk,
    input  logic rst,
    input  logic start,
    input  logic usePause,
    output logic done
);

    localparam int MaxCycles = (CountCycles > PauseCycles) ? CountCycles : PauseCycles;
    localparam int CountW    = $clog2(MaxCycles + 1);

    logic [CountW-1:0] remaining;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            remaining <= '0;
        end else if (start) begin
            // Select start countdown or stop pause
            if (usePause) begin
                remaining <= CountW'(PauseCycles);
            end else begin
                remaining <= CountW'(CountCycles);
            end
        end else if (remaining != '0) begin
            remaining <= remaining - 1'b1;
        end
    end

    // Held at zero until the next load
    assign done = (remaining == '0);

endmodule

// ==== design/trackSampler.sv ====
`timescale 1ns/1ps

module trackSampler
    import mazePkg::*;
#(
    parameter int StableCycles = 3
) (
    input  logic clk,
    input  logic rst,
    input  logic trackLeft,
    input  logic trackMid,
    input  logic trackRight,
    output roadT road
);

    localparam int CountW = $clog2(StableCycles + 1);

    logic [2:0]        syncFirst;
    logic [2:0]        syncSecond;
    logic [2:0]        candidate;
    logic [CountW-1:0] stableCount;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            syncFirst   <= 3'b000;
            syncSecond  <= 3'b000;
            candidate   <= 3'b000;
            stableCount <= '0;
            road        <= roadLost;
        end else begin
            // Two-flop synchronizer on the raw pins
            syncFirst  <= {trackLeft, trackMid, trackRight};
            syncSecond <= syncFirst;

            // Restart the run on any change
            if (syncSecond != candidate) begin
                candidate   <= syncSecond;
                stableCount <= CountW'(1);
            end else if (stableCount != CountW'(StableCycles)) begin
                stableCount <= stableCount + 1'b1;
            end

            // Last sample of a full run commits the pattern
            if (syncSecond == candidate && stableCount == CountW'(StableCycles - 1)) begin
                road <= roadT'(candidate);
            end
        end
    end

endmodule

// ==== design/mazePkg.sv ====
package mazePkg;

    // Navigation FSM states
    typedef enum logic [3:0] {
        navIdle       = 4'd0,
        navStart      = 4'd1,
        navCount      = 4'd2,
        navStraight   = 4'd3,
        navNudgeLeft  = 4'd4,
        navNudgeRight = 4'd5,
        navChoose     = 4'd6,
        navLeft       = 4'd7,
        navRight      = 4'd8,
        navBack       = 4'd9,
        navStop       = 4'd10,
        navError      = 4'd11
    } navStateT;

    // Sensor pattern as {left, mid, right}
    typedef enum logic [2:0] {
        roadLost        = 3'b000,
        roadRightSlight = 3'b001,
        roadStraight    = 3'b010,
        roadRight       = 3'b011,
        roadLeftSlight  = 3'b100,
        roadFork        = 3'b101,
        roadLeft        = 3'b110,
        roadCross       = 3'b111
    } roadT;

    // Choice remembered at each junction
    typedef enum logic [1:0] {
        decNone     = 2'd0,
        decStraight = 2'd1,
        decLeft     = 2'd2,
        decRight    = 2'd3
    } decisionT;

    typedef enum logic [1:0] {
        opPush,
        opReplace,
        opPop
    } stackOpT;

    // Per-wheel direction
    typedef enum logic [1:0] {
        driveStop,
        driveForward,
        driveReverse
    } driveT;

endpackage
